// File: trace_pkg.sv
`default_nettype none

package trace_pkg;

	////////////////////
	// Trace record
	////////////////////

	// One step of the processor as seen on its trace port
	typedef struct packed {
		logic [31:0] instr;
		logic [31:0] addr;
		logic [31:0] wdata;
		logic        wr;
	} trace_rec_t;

	////////////////////
	// Text output
	////////////////////

	// Eight characters with byte 7 leaving the UART first
	typedef logic [7:0][7:0] ascii_word_t;

	// Word position inside one line of text
	typedef enum logic [1:0] {
		SEL_INSTR  = 2'd0,
		SEL_ADDR   = 2'd1,
		SEL_WDATA  = 2'd2,
		SEL_STATUS = 2'd3
	} word_sel_t;

	localparam logic [7:0] CH_CR   = 8'h0d;
	localparam logic [7:0] CH_LF   = 8'h0a;
	localparam logic [7:0] CH_ZERO = 8'h30;
	localparam logic [7:0] CH_A    = 8'h41;

	////////////////////
	// Instruction fields
	////////////////////

	// All-zero opcode marks the end of the program
	localparam int OPCODE_MSB = 31;
	localparam int OPCODE_LSB = 26;

endpackage

`default_nettype wire

// File: hex_line_fmt.sv
`timescale 1ns/1ps
`default_nettype none

module hex_line_fmt import trace_pkg::*; (
	input  trace_rec_t  rec,
	input  word_sel_t   sel,
	output ascii_word_t word
);

	logic [31:0] field;
	ascii_word_t digits;
	ascii_word_t status;

	// Nibble to upper-case hex character
	function automatic logic [7:0] hex_char(input logic [3:0] nib);
		logic [7:0] wide;
		wide = {4'h0, nib};
		if (nib < 4'd10) begin
			return CH_ZERO + wide;
		end
		return CH_A + (wide - 8'd10);
	endfunction

	////////////////////
	// Field select
	////////////////////

	always_comb begin
		case (sel)
			SEL_INSTR: field = rec.instr;
			SEL_ADDR:  field = rec.addr;
			SEL_WDATA: field = rec.wdata;
			default:   field = '0;
		endcase
	end

	// Most significant nibble ends up in byte 7
	always_comb begin
		for (int i = 0; i < 8; i++) begin
			digits[i] = hex_char(field[4*i +: 4]);
		end
	end

	// Five zeros, write flag digit, then end of line
	assign status = {{5{CH_ZERO}}, hex_char({3'b000, rec.wr}), CH_CR, CH_LF};

	assign word = (sel == SEL_STATUS) ? status : digits;

endmodule

`default_nettype wire

// File: step_trace_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module step_trace_ctrl import trace_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  trace_rec_t trace,
	input  logic       fifo_empty,
	output trace_rec_t rec,
	output word_sel_t  sel,
	output logic       wr_en,
	output logic       stall,
	output logic       done
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_RUN,
		ST_W0,
		ST_W1,
		ST_W2,
		ST_W3
	} state_t;

	state_t state;
	state_t state_nxt;
	logic   done_q;
	logic   opcode_zero;
	logic   may_start;

	// Presented instruction ends the program
	assign opcode_zero = (trace.instr[OPCODE_MSB:OPCODE_LSB] == '0);

	// Previous line fully handed to the UART and not yet finished
	assign may_start = fifo_empty && !done_q;

	////////////////////
	// Step FSM
	////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= ST_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			ST_IDLE: begin
				if (may_start && !opcode_zero) begin
					state_nxt = ST_RUN;
				end
			end
			ST_RUN:  state_nxt = ST_W0;
			ST_W0:   state_nxt = ST_W1;
			ST_W1:   state_nxt = ST_W2;
			ST_W2:   state_nxt = ST_W3;
			default: state_nxt = ST_IDLE;
		endcase
	end

	// Sticky end of program flag
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			done_q <= 1'b0;
		end else if (state == ST_IDLE && may_start && opcode_zero) begin
			done_q <= 1'b1;
		end
	end

	// Processor advances on the same edge
	always_ff @(posedge clk) begin
		if (state == ST_RUN) begin
			rec <= trace;
		end
	end

	////////////////////
	// Outputs
	////////////////////

	always_comb begin
		case (state)
			ST_W1:   sel = SEL_ADDR;
			ST_W2:   sel = SEL_WDATA;
			ST_W3:   sel = SEL_STATUS;
			default: sel = SEL_INSTR;
		endcase
	end

	assign wr_en = (state == ST_W0) || (state == ST_W1) || (state == ST_W2) || (state == ST_W3);
	assign stall = (state != ST_RUN);
	assign done  = done_q;

endmodule

`default_nettype wire

// File: width_down_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module width_down_fifo import trace_pkg::*; #(
	parameter int FIFO_WORDS = 2
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        wr_en,
	input  ascii_word_t wdata,
	input  logic        rd_en,
	output logic [7:0]  rdata,
	output logic        empty,
	output logic        full
);

	localparam int AW = $clog2(FIFO_WORDS);

	ascii_word_t mem [FIFO_WORDS];

	// Extra top bit tells full from empty
	logic [AW:0] wr_ptr;
	logic [AW:0] rd_ptr;
	logic [2:0]  byte_ptr;
	logic        do_wr;
	logic        do_rd;
	logic        last_byte;

	assign do_wr     = wr_en && !full;
	assign do_rd     = rd_en && !empty;
	assign last_byte = (byte_ptr == 3'd0);

	////////////////////
	// Word storage
	////////////////////

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr[AW-1:0]] <= wdata;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wr_ptr <= '0;
		end else if (do_wr) begin
			wr_ptr <= wr_ptr + 1'b1;
		end
	end

	////////////////////
	// Byte read side
	////////////////////

	// Walk the head word from byte 7 down, then retire it
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rd_ptr   <= '0;
			byte_ptr <= 3'd7;
		end else if (do_rd) begin
			if (last_byte) begin
				rd_ptr   <= rd_ptr + 1'b1;
				byte_ptr <= 3'd7;
			end else begin
				byte_ptr <= byte_ptr - 3'd1;
			end
		end
	end

	// Show-ahead output
	assign rdata = mem[rd_ptr[AW-1:0]][byte_ptr];

	assign empty = (wr_ptr == rd_ptr);
	assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

endmodule

`default_nettype wire

// File: uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
	parameter int CLKS_PER_BIT = 16
) (
	input  logic       clk,
	input  logic       rst,
	input  logic       start,
	input  logic [7:0] data,
	output logic       ready,
	output logic       txd
);

	localparam int CW = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
	localparam logic [CW-1:0] LAST_CLK = CW'(CLKS_PER_BIT - 1);

	logic          busy;
	logic [CW-1:0] clk_cnt;
	logic [3:0]    bit_cnt;
	// Stop, data, start; bit 0 is on the line
	logic [9:0]    shreg;
	logic          bit_end;

	assign bit_end = (clk_cnt == LAST_CLK);

	////////////////////
	// Frame sequencer
	////////////////////

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			busy    <= 1'b0;
			clk_cnt <= '0;
			bit_cnt <= 4'd0;
			shreg   <= '1;
		end else if (!busy) begin
			if (start) begin
				busy    <= 1'b1;
				clk_cnt <= '0;
				bit_cnt <= 4'd0;
				shreg   <= {1'b1, data, 1'b0};
			end
		end else if (bit_end) begin
			clk_cnt <= '0;
			// Ones fill in behind, so the line idles high
			shreg   <= {1'b1, shreg[9:1]};
			if (bit_cnt == 4'd9) begin
				busy <= 1'b0;
			end else begin
				bit_cnt <= bit_cnt + 4'd1;
			end
		end else begin
			clk_cnt <= clk_cnt + 1'b1;
		end
	end

	assign ready = !busy;
	assign txd   = shreg[0];

endmodule

`default_nettype wire

// File: cpu_trace_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_trace_top import trace_pkg::*; #(
	parameter int CLKS_PER_BIT = 16,
	parameter int FIFO_WORDS   = 2
) (
	input  logic       clk,
	input  logic       rst,
	input  trace_rec_t trace,
	output logic       stall,
	output logic       done,
	output logic       txd
);

	trace_rec_t  rec;
	word_sel_t   sel;
	ascii_word_t word;
	logic        wr_en;
	logic        fifo_empty;
	logic        fifo_full;
	logic [7:0]  fifo_byte;
	logic        uart_ready;
	logic        pop;

	////////////////////
	// Step control and text
	////////////////////

	step_trace_ctrl u_ctrl (
		.clk        (clk),
		.rst        (rst),
		.trace      (trace),
		.fifo_empty (fifo_empty),
		.rec        (rec),
		.sel        (sel),
		.wr_en      (wr_en),
		.stall      (stall),
		.done       (done)
	);

	hex_line_fmt u_fmt (
		.rec  (rec),
		.sel  (sel),
		.word (word)
	);

	////////////////////
	// Byte path to the line
	////////////////////

	width_down_fifo #(
		.FIFO_WORDS (FIFO_WORDS)
	) u_fifo (
		.clk   (clk),
		.rst   (rst),
		.wr_en (wr_en),
		.wdata (word),
		.rd_en (pop),
		.rdata (fifo_byte),
		.empty (fifo_empty),
		.full  (fifo_full)
	);

	// One strobe pops the FIFO and starts the frame
	assign pop = !fifo_empty && uart_ready;

	uart_tx #(
		.CLKS_PER_BIT (CLKS_PER_BIT)
	) u_uart (
		.clk   (clk),
		.rst   (rst),
		.start (pop),
		.data  (fifo_byte),
		.ready (uart_ready),
		.txd   (txd)
	);

endmodule

`default_nettype wire

// File: trace_checker.sv
`timescale 1ns/1ps
`default_nettype none

module trace_checker (
	input logic clk,
	input logic rst,
	input logic stall,
	input logic done,
	input logic wr_en,
	input logic fifo_full,
	input logic uart_ready,
	input logic txd
);

	////////////////////
	// Controller
	////////////////////

	// Processor stays held in the first cycle out of reset
	a_stall_after_reset: assert property (@(posedge clk) $fell(rst) |-> stall)
		else $error("stall low in the first cycle after reset");

	a_no_write_when_full: assert property (@(posedge clk) disable iff (rst)
		!(wr_en && fifo_full))
		else $error("FIFO written while full");

	// End of program is sticky
	a_done_sticky: assert property (@(posedge clk) disable iff (rst) done |=> done)
		else $error("done fell");

	////////////////////
	// Serial line
	////////////////////

	a_idle_high: assert property (@(posedge clk) disable iff (rst) uart_ready |-> txd)
		else $error("txd low while the UART is idle");

endmodule

bind cpu_trace_top trace_checker u_checker (
	.clk        (clk),
	.rst        (rst),
	.stall      (stall),
	.done       (done),
	.wr_en      (wr_en),
	.fifo_full  (fifo_full),
	.uart_ready (uart_ready),
	.txd        (txd)
);

`default_nettype wire

// File: tb_cpu_trace.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_trace import trace_pkg::*; ();

	localparam int CLKS_PER_BIT   = 8;
	localparam int FIFO_WORDS     = 4;
	localparam int CLK_PERIOD     = 4;
	localparam int N_FIXED        = 3;
	localparam int N_RAND         = 5;
	localparam int N_STEPS        = N_FIXED + N_RAND;
	localparam int CHARS_PER_LINE = 32;
	// Serial time of every line, a quarter on top, plus reset and slack
	localparam longint LINE_NS     = longint'(CHARS_PER_LINE) * 10 * CLKS_PER_BIT * CLK_PERIOD;
	localparam longint WATCHDOG_NS = (N_STEPS * LINE_NS * 5) / 4 + 2000;

	logic       clk;
	logic       rst;
	trace_rec_t trace;
	logic       stall;
	logic       done;
	logic       txd;

	// Program entries, terminator last, and the text each step must produce
	trace_rec_t  prog [N_STEPS + 1];
	ascii_word_t exp_words [N_STEPS * 4];
	int          pc;
	int          stall_lows = 0;
	int          frames_started = 0;
	logic        stall_low_prev = 1'b0;
	logic [7:0]  rx_q [$];

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	cpu_trace_top #(
		.CLKS_PER_BIT (CLKS_PER_BIT),
		.FIFO_WORDS   (FIFO_WORDS)
	) DUT (
		.clk   (clk),
		.rst   (rst),
		.trace (trace),
		.stall (stall),
		.done  (done),
		.txd   (txd)
	);

	////////////////////
	// Reporting
	////////////////////

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Testbench failed");
		$fatal(1, "run stopped at first failure");
	endtask

	task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp) begin
			stop_run($sformatf("Error at %0t ns: %s is 8'h%h, expected 8'h%h",
				$time, what, got, exp));
		end
	endtask

	task automatic check_line(input string what, input ascii_word_t got, input ascii_word_t exp);
		if (got !== exp) begin
			stop_run($sformatf("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp));
		end
	endtask

	task automatic check_flag(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			stop_run($sformatf("Error at %0t ns: %s is %b, expected %b", $time, what, got, exp));
		end
	endtask

	task automatic check_count(input string what, input int got, input int exp);
		if (got != exp) begin
			stop_run($sformatf("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp));
		end
	endtask

	////////////////////
	// Expected text
	////////////////////

	function automatic ascii_word_t hex_text(input logic [31:0] value);
		string       digits;
		ascii_word_t w;
		digits = "0123456789ABCDEF";
		// First character out carries the top nibble
		for (int k = 0; k < 8; k++) begin
			w[7 - k] = digits[int'(value[31 - 4*k -: 4])];
		end
		return w;
	endfunction

	function automatic trace_rec_t make_rec(input logic [31:0] instr, input logic [31:0] addr,
		input logic [31:0] wdata, input logic wr);
		trace_rec_t r;
		r.instr = instr;
		r.addr  = addr;
		r.wdata = wdata;
		r.wr    = wr;
		return r;
	endfunction

	task automatic build_table();
		trace_rec_t  r;
		logic [31:0] rnd;
		prog[0] = make_rec(32'h8C43_0010, 32'h0000_1000, 32'h0000_0000, 1'b0);
		prog[1] = make_rec(32'hAC45_0004, 32'h0000_1004, 32'hDEAD_BEEF, 1'b1);
		prog[2] = make_rec(32'h2042_00FF, 32'hFFFF_FFFC, 32'h0123_4567, 1'b0);
		for (int i = N_FIXED; i < N_STEPS; i++) begin
			r.instr = $urandom();
			r.addr  = $urandom();
			r.wdata = $urandom();
			rnd     = $urandom();
			r.wr    = rnd[0];
			// A zero opcode would end the program early
			if (r.instr[31:26] == 6'd0) begin
				r.instr[31] = 1'b1;
			end
			prog[i] = r;
		end
		// R-type add with a nonzero word but a zero opcode
		prog[N_STEPS] = make_rec(32'h0062_2020, 32'h0000_2000, 32'h1234_5678, 1'b1);
		for (int s = 0; s < N_STEPS; s++) begin
			exp_words[4*s]     = hex_text(prog[s].instr);
			exp_words[4*s + 1] = hex_text(prog[s].addr);
			exp_words[4*s + 2] = hex_text(prog[s].wdata);
			exp_words[4*s + 3] = {"00000", (prog[s].wr ? "1" : "0"), 8'h0d, 8'h0a};
		end
	endtask

	////////////////////
	// Processor model and monitors
	////////////////////

	// Next entry shows up on the edge that lets the processor run
	always @(posedge clk) begin
		if (rst) begin
			pc    <= 0;
			trace <= prog[0];
		end else if (!stall) begin
			pc    <= pc + 1;
			trace <= prog[pc + 1];
		end
	end

	always @(posedge clk) begin
		if (!rst && stall_lows == 0) begin
			check_flag("txd before first step", txd, 1'b1);
		end
		if (!rst && stall_lows < N_STEPS) begin
			check_flag("done while stepping", done, 1'b0);
		end
		if (!rst && !stall) begin
			if (stall_low_prev) begin
				stop_run("The processor was released for more than one cycle in a step");
			end
			if (stall_lows >= N_STEPS) begin
				stop_run("The processor was released on the zero-opcode entry");
			end
			check_count("characters sent before step", frames_started, stall_lows * CHARS_PER_LINE);
			stall_lows++;
		end
		stall_low_prev = !rst && !stall;
	end

	// Samples each bit at its centre
	initial begin : serial_decoder
		logic [7:0] data;
		@(negedge rst);
		forever begin
			@(posedge clk);
			if (txd === 1'b0) begin
				frames_started++;
				repeat (CLKS_PER_BIT / 2 - 1) @(posedge clk);
				if (txd !== 1'b0) begin
					stop_run("The start bit on txd did not last to its centre");
				end
				for (int b = 0; b < 8; b++) begin
					repeat (CLKS_PER_BIT) @(posedge clk);
					data[b] = txd;
				end
				repeat (CLKS_PER_BIT) @(posedge clk);
				if (txd !== 1'b1) begin
					stop_run("A frame on txd has no stop bit");
				end
				rx_q.push_back(data);
			end
		end
	end

	task automatic next_byte(output logic [7:0] b);
		while (rx_q.size() == 0) begin
			@(posedge clk);
		end
		b = rx_q.pop_front();
	endtask

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("Timeout at %0t ns: the trace run did not finish in time", $time);
		$display("Testbench failed");
		$fatal(1, "watchdog expired");
	end

	////////////////////
	// Main sequence
	////////////////////

	initial begin : main
		int unsigned seed_ret;
		logic [7:0]  rx;
		ascii_word_t got;
		rst   <= 1'b1;
		trace <= '0;
		seed_ret = $urandom(32'hfef1);
		build_table();
		repeat (8) @(posedge clk);
		check_flag("stall in reset", stall, 1'b1);
		check_flag("done in reset", done, 1'b0);
		check_flag("txd in reset", txd, 1'b1);
		rst <= 1'b0;
		for (int s = 0; s < N_STEPS; s++) begin
			for (int w = 0; w < 4; w++) begin
				for (int c = 7; c >= 0; c--) begin
					next_byte(rx);
					got[c] = rx;
				end
				// Status word tail is the write digit and the line end
				if (w == 3) begin
					check_byte($sformatf("step %0d write digit", s), got[2],
						prog[s].wr ? "1" : "0");
					check_byte($sformatf("step %0d CR", s), got[1], CH_CR);
					check_byte($sformatf("step %0d LF", s), got[0], CH_LF);
				end
				check_line($sformatf("step %0d word %0d", s, w), got, exp_words[4*s + w]);
			end
		end
		while (done !== 1'b1) begin
			@(posedge clk);
		end
		// Nothing may move once the program has ended
		repeat (20 * CLKS_PER_BIT) begin
			@(posedge clk);
			check_flag("done after end", done, 1'b1);
			check_flag("stall after end", stall, 1'b1);
		end
		check_count("steps released", stall_lows, N_STEPS);
		check_count("undecoded bytes", rx_q.size(), 0);
		check_count("serial characters", frames_started, N_STEPS * CHARS_PER_LINE);
		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
trace_pkg.sv
hex_line_fmt.sv
step_trace_ctrl.sv
width_down_fifo.sv
uart_tx.sv
cpu_trace_top.sv
trace_checker.sv
tb_cpu_trace.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := tb_cpu_trace
FILELIST  := all.f
VFLAGS    := --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS := --lint-only -Wall --timing
OBJ_DIR   := obj_dir
LOG       := sim.log
SRCS      := $(wildcard *.sv)

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
